// ==== decode_input.txt ====
// valid flush instr pc | expected: wb_valid rd wb_data redirect redirect_pc
// all fields hex, one instruction per line, pc steps by 4 from 0x100
1 0 00500093 00000100 1 01 00000005 0 00000000 // addi x1, x0, 5
1 0 ffd00113 00000104 1 02 fffffffd 0 00000000 // addi x2, x0, -3
1 0 12345237 00000108 1 04 12345000 0 00000000 // lui x4, 0x12345
1 0 002081b3 0000010c 1 03 00000002 0 00000000 // add x3, x1, x2
1 0 402082b3 00000110 1 05 00000008 0 00000000 // sub x5, x1, x2
1 0 40115333 00000114 1 06 ffffffff 0 00000000 // sra x6, x2, x1
1 0 001153b3 00000118 1 07 07ffffff 0 00000000 // srl x7, x2, x1
1 0 00708013 0000011c 1 00 0000000c 0 00000000 // addi x0, x1, 7
1 0 00001417 00000120 1 08 00001120 0 00000000 // auipc x8, 0x1
1 0 001004b3 00000124 1 09 00000005 0 00000000 // add x9, x0, x1
1 0 00108863 00000128 0 00 00000000 1 00000138 // beq x1, x1, +16
1 0 fe209ce3 0000012c 0 00 00000000 1 00000124 // bne x1, x2, -8
1 0 00114863 00000130 0 00 00000000 1 00000140 // blt x2, x1, +16
1 0 00116863 00000134 0 00 00000000 0 00000000 // bltu x2, x1, +16
1 0 fe115ce3 00000138 0 00 00000000 0 00000000 // bge x2, x1, -8
1 0 fe117ce3 0000013c 0 00 00000000 1 00000134 // bgeu x2, x1, -8
1 0 0200056f 00000140 1 0a 00000144 1 00000160 // jal x10, +32
1 0 004085e7 00000144 1 0b 00000148 1 00000008 // jalr x11, 4(x1)
1 1 00100613 00000148 0 00 00000000 0 00000000 // addi x12, x0, 1 flushed
0 0 000006ef 0000014c 0 00 00000000 0 00000000 // jal x13, 0 not valid
1 0 0000a703 00000150 0 00 00000000 0 00000000 // lw x14, 0(x1)
1 0 00112023 00000154 0 00 00000000 0 00000000 // sw x1, 0(x2)
1 0 001607b3 00000158 1 0f 00000005 0 00000000 // add x15, x12, x1

// ==== sim.f ====
rv32i_pkg.sv
ctrl_pkg.sv
regfile.sv
control_rom.sv
id_stage.sv
id_ex_reg.sv
ex_stage.sv
decode_top.sv
tb_decode_top.sv

// ==== Makefile ====
TOP := tb_decode_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f $(shell cat sim.f)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== tb_decode_top.sv ====
`default_nettype none

module tb_decode_top;

    localparam int num_vec = 23;       // instruction lines in the data file
    localparam int num_fld = 9;        // hex fields per line
    localparam int reset_timeout = 50;
    localparam int idle_cycles = 2;

    logic        clk;
    logic        reset_i = 1'b1;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        flush_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        redirect_o;
    logic [31:0] redirect_pc_o;

    logic [31:0] vec_mem [0:255];

    decode_top decode_top_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .flush_i       (flush_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (10) @(posedge clk);
        #1 reset_i = 1'b0;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic load_vectors();
        integer fd;
        logic [7:0] base;
        for (int k = 0; k < 256; k++) begin
            vec_mem[k[7:0]] = 32'ha5a5_0000 ^ k;  // never a legal flag value
        end
        fd = $fopen("decode_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file decode_input.txt");
        end
        $fclose(fd);
        $readmemh("decode_input.txt", vec_mem);
        for (int v = 0; v < num_vec; v++) begin
            base = 8'(v * num_fld);
            if (vec_mem[base] > 32'd1 || vec_mem[base + 8'd1] > 32'd1
                    || vec_mem[base + 8'd4] > 32'd1 || vec_mem[base + 8'd7] > 32'd1) begin
                abort_run($sformatf("vector file is short or malformed at line %0d", v));
            end
        end
    endtask

    task automatic drive_idle();
        instr_valid_i = 1'b0;
        flush_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
    endtask

    task automatic apply_vector(input int v);
        logic [7:0] base;
        base = 8'(v * num_fld);
        instr_valid_i = vec_mem[base][0];
        flush_i = vec_mem[base + 8'd1][0];
        instr_i = vec_mem[base + 8'd2];
        pc_i = vec_mem[base + 8'd3];
    endtask

    task automatic check_vector(input int v);
        logic [7:0] base;
        base = 8'(v * num_fld);
        check($sformatf("vec %0d wb_valid", v), vec_mem[base + 8'd4], {31'b0, wb_valid_o});
        if (vec_mem[base + 8'd4][0]) begin  // rd and data only matter on a write
            check($sformatf("vec %0d wb_rd", v), vec_mem[base + 8'd5], {27'b0, wb_rd_o});
            check($sformatf("vec %0d wb_data", v), vec_mem[base + 8'd6], wb_data_o);
        end
        check($sformatf("vec %0d redirect", v), vec_mem[base + 8'd7], {31'b0, redirect_o});
        if (vec_mem[base + 8'd7][0]) begin
            check($sformatf("vec %0d redirect_pc", v), vec_mem[base + 8'd8], redirect_pc_o);
        end
    endtask

    initial begin : main
        int wait_cycles;
        drive_idle();
        load_vectors();
        wait_cycles = 0;
        while (reset_i) begin
            @(posedge clk);
            #5;  // mid cycle
            check("reset wb_valid", 32'd0, {31'b0, wb_valid_o});
            check("reset redirect", 32'd0, {31'b0, redirect_o});
            wait_cycles++;
            if (wait_cycles > reset_timeout) begin
                abort_run("reset did not end within the timeout");
            end
        end
        for (int c = 0; c < idle_cycles; c++) begin
            @(posedge clk);
            #5;
            check("idle wb_valid", 32'd0, {31'b0, wb_valid_o});
            check("idle redirect", 32'd0, {31'b0, redirect_o});
        end
        // each line is checked one cycle after it was driven
        for (int v = 0; v <= num_vec; v++) begin
            @(posedge clk);
            #1;
            if (v < num_vec) begin
                apply_vector(v);
            end else begin
                drive_idle();
            end
            #4;
            if (v > 0) begin
                check_vector(v - 1);
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_top.sv ====
`default_nettype none

module decode_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic        flush_i,
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o
);

    logic ctrl_valid, ctrl_load_rf, ctrl_alumux1, ctrl_alumux2, br_en;
    logic [ctrl_pkg::alu_op_w-1:0] ctrl_alu_op;
    logic [ctrl_pkg::wbmux_w-1:0] ctrl_wbmux;
    logic [ctrl_pkg::flow_w-1:0] ctrl_flow;
    logic [31:0] rs1_data, rs2_data, imm, pc;
    logic [4:0] rd;

    logic ex_ctrl_valid, ex_ctrl_load_rf, ex_ctrl_alumux1, ex_ctrl_alumux2, ex_br_en;
    logic [ctrl_pkg::alu_op_w-1:0] ex_ctrl_alu_op;
    logic [ctrl_pkg::wbmux_w-1:0] ex_ctrl_wbmux;
    logic [ctrl_pkg::flow_w-1:0] ex_ctrl_flow;
    logic [31:0] ex_rs1_data, ex_rs2_data, ex_imm, ex_pc;
    logic [4:0] ex_rd;

    id_stage id_stage_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .flush_i        (flush_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .wb_load_i      (wb_valid_o),  // writeback loop
        .wb_rd_i        (wb_rd_o),
        .wb_data_i      (wb_data_o),
        .ctrl_valid_o   (ctrl_valid),
        .ctrl_load_rf_o (ctrl_load_rf),
        .ctrl_alu_op_o  (ctrl_alu_op),
        .ctrl_alumux1_o (ctrl_alumux1),
        .ctrl_alumux2_o (ctrl_alumux2),
        .ctrl_wbmux_o   (ctrl_wbmux),
        .ctrl_flow_o    (ctrl_flow),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .imm_o          (imm),
        .pc_o           (pc),
        .rd_o           (rd),
        .br_en_o        (br_en)
    );

    id_ex_reg id_ex_reg_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .ctrl_valid_i      (ctrl_valid),
        .ctrl_load_rf_i    (ctrl_load_rf),
        .ctrl_alu_op_i     (ctrl_alu_op),
        .ctrl_alumux1_i    (ctrl_alumux1),
        .ctrl_alumux2_i    (ctrl_alumux2),
        .ctrl_wbmux_i      (ctrl_wbmux),
        .ctrl_flow_i       (ctrl_flow),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .imm_i             (imm),
        .pc_i              (pc),
        .rd_i              (rd),
        .br_en_i           (br_en),
        .ex_ctrl_valid_o   (ex_ctrl_valid),
        .ex_ctrl_load_rf_o (ex_ctrl_load_rf),
        .ex_ctrl_alu_op_o  (ex_ctrl_alu_op),
        .ex_ctrl_alumux1_o (ex_ctrl_alumux1),
        .ex_ctrl_alumux2_o (ex_ctrl_alumux2),
        .ex_ctrl_wbmux_o   (ex_ctrl_wbmux),
        .ex_ctrl_flow_o    (ex_ctrl_flow),
        .ex_rs1_data_o     (ex_rs1_data),
        .ex_rs2_data_o     (ex_rs2_data),
        .ex_imm_o          (ex_imm),
        .ex_pc_o           (ex_pc),
        .ex_rd_o           (ex_rd),
        .ex_br_en_o        (ex_br_en)
    );

    ex_stage ex_stage_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .ex_ctrl_valid_i   (ex_ctrl_valid),
        .ex_ctrl_load_rf_i (ex_ctrl_load_rf),
        .ex_ctrl_alu_op_i  (ex_ctrl_alu_op),
        .ex_ctrl_alumux1_i (ex_ctrl_alumux1),
        .ex_ctrl_alumux2_i (ex_ctrl_alumux2),
        .ex_ctrl_wbmux_i   (ex_ctrl_wbmux),
        .ex_ctrl_flow_i    (ex_ctrl_flow),
        .ex_rs1_data_i     (ex_rs1_data),
        .ex_rs2_data_i     (ex_rs2_data),
        .ex_imm_i          (ex_imm),
        .ex_pc_i           (ex_pc),
        .ex_rd_i           (ex_rd),
        .ex_br_en_i        (ex_br_en),
        .wb_load_o         (wb_valid_o),
        .wb_rd_o           (wb_rd_o),
        .wb_data_o         (wb_data_o),
        .redirect_o        (redirect_o),
        .redirect_pc_o     (redirect_pc_o)
    );

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`default_nettype none

module ex_stage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          ex_ctrl_valid_i,
    input  logic                          ex_ctrl_load_rf_i,
    input  logic [ctrl_pkg::alu_op_w-1:0] ex_ctrl_alu_op_i,
    input  logic                          ex_ctrl_alumux1_i,
    input  logic                          ex_ctrl_alumux2_i,
    input  logic [ctrl_pkg::wbmux_w-1:0]  ex_ctrl_wbmux_i,
    input  logic [ctrl_pkg::flow_w-1:0]   ex_ctrl_flow_i,
    input  logic [31:0]                   ex_rs1_data_i,
    input  logic [31:0]                   ex_rs2_data_i,
    input  logic [31:0]                   ex_imm_i,
    input  logic [31:0]                   ex_pc_i,
    input  logic [4:0]                    ex_rd_i,
    input  logic                          ex_br_en_i,
    output logic                          wb_load_o,
    output logic [4:0]                    wb_rd_o,
    output logic [31:0]                   wb_data_o,
    output logic                          redirect_o,
    output logic [31:0]                   redirect_pc_o
);

    logic [31:0] alu_a, alu_b, alu_out;

    assign alu_a = (ex_ctrl_alumux1_i == ctrl_pkg::alumux1_pc) ? ex_pc_i : ex_rs1_data_i;
    assign alu_b = (ex_ctrl_alumux2_i == ctrl_pkg::alumux2_rs2) ? ex_rs2_data_i : ex_imm_i;

    always_comb begin : alu
        case (ex_ctrl_alu_op_i)
            {1'b0, rv32i_pkg::alu_sll}: alu_out = alu_a << alu_b[4:0];
            {1'b0, rv32i_pkg::alu_sra}: alu_out = $signed(alu_a) >>> alu_b[4:0];
            {1'b0, rv32i_pkg::alu_sub}: alu_out = alu_a - alu_b;
            {1'b0, rv32i_pkg::alu_xor}: alu_out = alu_a ^ alu_b;
            {1'b0, rv32i_pkg::alu_srl}: alu_out = alu_a >> alu_b[4:0];
            {1'b0, rv32i_pkg::alu_or}:  alu_out = alu_a | alu_b;
            {1'b0, rv32i_pkg::alu_and}: alu_out = alu_a & alu_b;
            default: alu_out = alu_a + alu_b;  // alu_add
        endcase
    end

    always_comb begin : wb_mux
        case (ex_ctrl_wbmux_i)
            ctrl_pkg::wbmux_br:    wb_data_o = {31'b0, ex_br_en_i};
            ctrl_pkg::wbmux_u_imm: wb_data_o = ex_imm_i;
            ctrl_pkg::wbmux_pc4:   wb_data_o = ex_pc_i + 32'd4;  // link
            default: wb_data_o = alu_out;
        endcase
    end

    assign wb_load_o = ex_ctrl_load_rf_i;
    assign wb_rd_o = ex_rd_i;

    assign redirect_o = (ex_ctrl_flow_i == ctrl_pkg::flow_jal)
                     || (ex_ctrl_flow_i == ctrl_pkg::flow_jalr)
                     || (ex_ctrl_flow_i == ctrl_pkg::flow_branch && ex_br_en_i);
    assign redirect_pc_o = (ex_ctrl_flow_i == ctrl_pkg::flow_jalr)
                         ? ((ex_rs1_data_i + ex_imm_i) & ~32'd1)
                         : (ex_pc_i + ex_imm_i);

    // flush and invalid words reach execute with flow_seq
    a_redirect_valid: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |-> ex_ctrl_valid_i);

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`default_nettype none

module id_ex_reg (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          ctrl_valid_i,
    input  logic                          ctrl_load_rf_i,
    input  logic [ctrl_pkg::alu_op_w-1:0] ctrl_alu_op_i,
    input  logic                          ctrl_alumux1_i,
    input  logic                          ctrl_alumux2_i,
    input  logic [ctrl_pkg::wbmux_w-1:0]  ctrl_wbmux_i,
    input  logic [ctrl_pkg::flow_w-1:0]   ctrl_flow_i,
    input  logic [31:0]                   rs1_data_i,
    input  logic [31:0]                   rs2_data_i,
    input  logic [31:0]                   imm_i,
    input  logic [31:0]                   pc_i,
    input  logic [4:0]                    rd_i,
    input  logic                          br_en_i,
    output logic                          ex_ctrl_valid_o,
    output logic                          ex_ctrl_load_rf_o,
    output logic [ctrl_pkg::alu_op_w-1:0] ex_ctrl_alu_op_o,
    output logic                          ex_ctrl_alumux1_o,
    output logic                          ex_ctrl_alumux2_o,
    output logic [ctrl_pkg::wbmux_w-1:0]  ex_ctrl_wbmux_o,
    output logic [ctrl_pkg::flow_w-1:0]   ex_ctrl_flow_o,
    output logic [31:0]                   ex_rs1_data_o,
    output logic [31:0]                   ex_rs2_data_o,
    output logic [31:0]                   ex_imm_o,
    output logic [31:0]                   ex_pc_o,
    output logic [4:0]                    ex_rd_o,
    output logic                          ex_br_en_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_ctrl_valid_o <= 1'b0;  // nop word
            ex_ctrl_load_rf_o <= 1'b0;
            ex_ctrl_flow_o <= ctrl_pkg::flow_seq;
        end else begin
            ex_ctrl_valid_o <= ctrl_valid_i;
            ex_ctrl_load_rf_o <= ctrl_load_rf_i;
            ex_ctrl_flow_o <= ctrl_flow_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_ctrl_alu_op_o <= ctrl_alu_op_i;
        ex_ctrl_alumux1_o <= ctrl_alumux1_i;
        ex_ctrl_alumux2_o <= ctrl_alumux2_i;
        ex_ctrl_wbmux_o <= ctrl_wbmux_i;
        ex_rs1_data_o <= rs1_data_i;
        ex_rs2_data_o <= rs2_data_i;
        ex_imm_o <= imm_i;
        ex_pc_o <= pc_i;
        ex_rd_o <= rd_i;
        ex_br_en_o <= br_en_i;
    end

    // bubbles from the decode nop mux never write the register file
    a_nop_no_write: assert property (@(posedge clk) disable iff (reset_i)
        !ex_ctrl_valid_o |-> !ex_ctrl_load_rf_o);

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`default_nettype none

module id_stage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          instr_valid_i,
    input  logic                          flush_i,
    input  logic [31:0]                   instr_i,
    input  logic [31:0]                   pc_i,
    input  logic                          wb_load_i,
    input  logic [4:0]                    wb_rd_i,
    input  logic [31:0]                   wb_data_i,
    output logic                          ctrl_valid_o,
    output logic                          ctrl_load_rf_o,
    output logic [ctrl_pkg::alu_op_w-1:0] ctrl_alu_op_o,
    output logic                          ctrl_alumux1_o,
    output logic                          ctrl_alumux2_o,
    output logic [ctrl_pkg::wbmux_w-1:0]  ctrl_wbmux_o,
    output logic [ctrl_pkg::flow_w-1:0]   ctrl_flow_o,
    output logic [31:0]                   rs1_data_o,
    output logic [31:0]                   rs2_data_o,
    output logic [31:0]                   imm_o,
    output logic [31:0]                   pc_o,
    output logic [4:0]                    rd_o,
    output logic                          br_en_o
);

    rv32i_pkg::instr_u ins;
    logic load_rf, alumux1, alumux2, cmpmux, legal, issue;
    logic [ctrl_pkg::alu_op_w-1:0] alu_op;
    logic [ctrl_pkg::immsel_w-1:0] immsel;
    logic [ctrl_pkg::wbmux_w-1:0] wbmux;
    logic [ctrl_pkg::flow_w-1:0] flow;
    logic [2:0] cmpop;
    logic [31:0] cmp_b;

    assign ins = instr_i;
    assign issue = instr_valid_i & legal & ~flush_i;
    assign pc_o = pc_i;
    assign rd_o = ins.r_fmt.rd;

    control_rom control_rom_i (
        .instr_i   (instr_i),
        .load_rf_o (load_rf),
        .alu_op_o  (alu_op),
        .alumux1_o (alumux1),
        .alumux2_o (alumux2),
        .immsel_o  (immsel),
        .wbmux_o   (wbmux),
        .cmpmux_o  (cmpmux),
        .cmpop_o   (cmpop),
        .flow_o    (flow),
        .legal_o   (legal)
    );

    regfile regfile_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .load_i     (wb_load_i),
        .rd_i       (wb_rd_i),
        .data_i     (wb_data_i),
        .rs1_i      (ins.i_fmt.rs1),
        .rs2_i      (ins.s_fmt.rs2),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

    always_comb begin : imm_gen
        case (immsel)
            ctrl_pkg::imm_i: imm_o = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
            ctrl_pkg::imm_u: imm_o = {ins.u_fmt.imm, 12'h000};
            ctrl_pkg::imm_b: imm_o = {{20{ins.b_fmt.imm12}}, ins.b_fmt.imm11,
                                      ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
            ctrl_pkg::imm_j: imm_o = {{12{ins.j_fmt.imm20}}, ins.j_fmt.imm19_12,
                                      ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};
            default: imm_o = '0;
        endcase
    end

    assign cmp_b = (cmpmux == ctrl_pkg::cmpmux_imm) ? imm_o : rs2_data_o;

    always_comb begin : branch_cmp
        case (cmpop)
            rv32i_pkg::beq:  br_en_o = (rs1_data_o == cmp_b);
            rv32i_pkg::bne:  br_en_o = (rs1_data_o != cmp_b);
            rv32i_pkg::blt:  br_en_o = ($signed(rs1_data_o) < $signed(cmp_b));
            rv32i_pkg::bge:  br_en_o = ($signed(rs1_data_o) >= $signed(cmp_b));
            rv32i_pkg::bltu: br_en_o = (rs1_data_o < cmp_b);
            rv32i_pkg::bgeu: br_en_o = (rs1_data_o >= cmp_b);
            default: br_en_o = 1'b0;
        endcase
    end

    always_comb begin : nop_mux
        ctrl_valid_o = issue;
        if (issue) begin
            ctrl_load_rf_o = load_rf;
            ctrl_alu_op_o = alu_op;
            ctrl_alumux1_o = alumux1;
            ctrl_alumux2_o = alumux2;
            ctrl_wbmux_o = wbmux;
            ctrl_flow_o = flow;
        end else begin
            ctrl_load_rf_o = 1'b0;  // bubble
            ctrl_alu_op_o = {1'b0, rv32i_pkg::alu_add};
            ctrl_alumux1_o = ctrl_pkg::alumux1_rs1;
            ctrl_alumux2_o = ctrl_pkg::alumux2_imm;
            ctrl_wbmux_o = ctrl_pkg::wbmux_alu;
            ctrl_flow_o = ctrl_pkg::flow_seq;
        end
    end

endmodule

`default_nettype wire

// ==== control_rom.sv ====
`default_nettype none

module control_rom (
    input  logic [31:0]                   instr_i,
    output logic                          load_rf_o,
    output logic [ctrl_pkg::alu_op_w-1:0] alu_op_o,
    output logic                          alumux1_o,
    output logic                          alumux2_o,
    output logic [ctrl_pkg::immsel_w-1:0] immsel_o,
    output logic [ctrl_pkg::wbmux_w-1:0]  wbmux_o,
    output logic                          cmpmux_o,
    output logic [2:0]                    cmpop_o,
    output logic [ctrl_pkg::flow_w-1:0]   flow_o,
    output logic                          legal_o
);

    rv32i_pkg::instr_u ins;
    logic [2:0] alu3;

    assign ins = instr_i;
    assign alu_op_o = {1'b0, alu3};

    always_comb begin
        load_rf_o = 1'b0;  // nop fields
        alu3 = rv32i_pkg::alu_add;
        alumux1_o = ctrl_pkg::alumux1_rs1;
        alumux2_o = ctrl_pkg::alumux2_imm;
        immsel_o = ctrl_pkg::imm_i;
        wbmux_o = ctrl_pkg::wbmux_alu;
        cmpmux_o = ctrl_pkg::cmpmux_rs2;
        cmpop_o = rv32i_pkg::beq;
        flow_o = ctrl_pkg::flow_seq;
        legal_o = 1'b0;
        case (ins.r_fmt.opcode)
            rv32i_pkg::op_lui: begin
                load_rf_o = 1'b1;
                immsel_o = ctrl_pkg::imm_u;
                wbmux_o = ctrl_pkg::wbmux_u_imm;
                legal_o = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                load_rf_o = 1'b1;
                alumux1_o = ctrl_pkg::alumux1_pc;
                immsel_o = ctrl_pkg::imm_u;
                legal_o = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                load_rf_o = 1'b1;
                immsel_o = ctrl_pkg::imm_j;
                wbmux_o = ctrl_pkg::wbmux_pc4;
                flow_o = ctrl_pkg::flow_jal;
                legal_o = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                load_rf_o = 1'b1;
                wbmux_o = ctrl_pkg::wbmux_pc4;
                flow_o = ctrl_pkg::flow_jalr;
                legal_o = 1'b1;
            end
            rv32i_pkg::op_br: begin
                immsel_o = ctrl_pkg::imm_b;
                cmpop_o = ins.b_fmt.funct3;
                flow_o = ctrl_pkg::flow_branch;
                legal_o = (ins.b_fmt.funct3[2:1] != 2'b01);  // 010/011 reserved
            end
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                load_rf_o = 1'b1;
                legal_o = 1'b1;
                if (ins.r_fmt.opcode == rv32i_pkg::op_reg) begin
                    alumux2_o = ctrl_pkg::alumux2_rs2;
                end else begin
                    cmpmux_o = ctrl_pkg::cmpmux_imm;  // slti/sltiu
                end
                case (ins.r_fmt.funct3)
                    rv32i_pkg::f3_add: begin
                        if (ins.r_fmt.opcode == rv32i_pkg::op_reg && ins.r_fmt.funct7[5]) begin
                            alu3 = rv32i_pkg::alu_sub;
                        end
                    end
                    rv32i_pkg::f3_sll: alu3 = rv32i_pkg::alu_sll;
                    rv32i_pkg::f3_slt: begin
                        cmpop_o = rv32i_pkg::blt;
                        wbmux_o = ctrl_pkg::wbmux_br;
                    end
                    rv32i_pkg::f3_sltu: begin
                        cmpop_o = rv32i_pkg::bltu;
                        wbmux_o = ctrl_pkg::wbmux_br;
                    end
                    rv32i_pkg::f3_xor: alu3 = rv32i_pkg::alu_xor;
                    rv32i_pkg::f3_sr: begin
                        alu3 = ins.r_fmt.funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
                    end
                    rv32i_pkg::f3_or: alu3 = rv32i_pkg::alu_or;
                    rv32i_pkg::f3_and: alu3 = rv32i_pkg::alu_and;
                    default: alu3 = rv32i_pkg::alu_add;
                endcase
            end
            rv32i_pkg::op_load, rv32i_pkg::op_store: legal_o = 1'b0;  // no data memory
            default: legal_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        load_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] data_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i[4:0]] <= '0;
            end
        end else if (load_i && rd_i != 5'd0) begin  // x0 writes dropped
            regs[rd_i] <= data_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

    // x0 reads zero whatever was written to it
    a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
        (rs1_i == 5'd0) |-> (rs1_data_o == '0));

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    localparam int alu_op_w = 4;
    localparam int immsel_w = 2;
    localparam int wbmux_w  = 2;
    localparam int flow_w   = 2;

    localparam logic alumux1_rs1 = 1'b0;
    localparam logic alumux1_pc  = 1'b1;
    localparam logic alumux2_imm = 1'b0;
    localparam logic alumux2_rs2 = 1'b1;

    localparam logic [immsel_w-1:0] imm_i = 2'd0;
    localparam logic [immsel_w-1:0] imm_u = 2'd1;
    localparam logic [immsel_w-1:0] imm_b = 2'd2;
    localparam logic [immsel_w-1:0] imm_j = 2'd3;

    localparam logic [wbmux_w-1:0] wbmux_alu   = 2'd0;
    localparam logic [wbmux_w-1:0] wbmux_br    = 2'd1;  // slt/sltu result
    localparam logic [wbmux_w-1:0] wbmux_u_imm = 2'd2;
    localparam logic [wbmux_w-1:0] wbmux_pc4   = 2'd3;

    localparam logic cmpmux_rs2 = 1'b0;
    localparam logic cmpmux_imm = 1'b1;

    localparam logic [flow_w-1:0] flow_seq    = 2'd0;
    localparam logic [flow_w-1:0] flow_branch = 2'd1;
    localparam logic [flow_w-1:0] flow_jal    = 2'd2;
    localparam logic [flow_w-1:0] flow_jalr   = 2'd3;

endpackage

`default_nettype wire

// ==== rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    localparam logic [2:0] f3_add  = 3'b000;  // add/sub/addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl/sra by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] alu_add = 3'b000;
    localparam logic [2:0] alu_sll = 3'b001;
    localparam logic [2:0] alu_sra = 3'b010;
    localparam logic [2:0] alu_sub = 3'b011;
    localparam logic [2:0] alu_xor = 3'b100;
    localparam logic [2:0] alu_srl = 3'b101;
    localparam logic [2:0] alu_or  = 3'b110;
    localparam logic [2:0] alu_and = 3'b111;

    localparam logic [2:0] beq  = 3'b000;  // same as branch funct3
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire
